//--- design/cpu_defines.svh
// CPU bus master constants
// Widths and synchronizer depth shared by the package and the RTL

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of the cycle state encoding
`define CPU_STATE_W 4

// Flip-flop stages on every asynchronous bus input
// 2 is the safe default, 1 trades MTBF for a cycle of latency
`define SYNC_STAGES 2

`endif

//--- design/cpuBusPkg.sv
// CPU bus master types
// Cycle states, decoded port size and transfer direction

`include "cpu_defines.svh"

package cpuBusPkg;

    // Cycle states of the bus master
    typedef enum logic [`CPU_STATE_W-1:0] {
        ST_IDLE      = 4'd0,
        ST_REQ       = 4'd1,   // BREQ out, waiting for grant and idle bus
        ST_TAKE      = 4'd2,   // Bus taken, BGACK asserted
        ST_ADDR      = 4'd3,   // PAS asserted
        ST_DATA      = 4'd4,   // PDS asserted, awaiting termination
        ST_GAP       = 4'd5,   // Strobes released, waiting for DSACK release
        ST_ADDR2     = 4'd6,   // Second half on a 16-bit port
        ST_DATA2     = 4'd7,
        ST_STEP      = 4'd8,   // FIFO and address step
        ST_FLUSHSTOP = 4'd9
    } cpuState_e;

    // Port size from the DSACK pair
    typedef enum logic [1:0] {
        PORT_NONE = 2'd0,
        PORT_16   = 2'd1,
        PORT_32   = 2'd2
    } portSize_e;

    // Transfer direction as seen from memory
    typedef enum logic {
        DIR_TO_FIFO   = 1'b0,  // Memory read
        DIR_FROM_FIFO = 1'b1   // Memory write
    } dmaDir_e;

endpackage

//--- design/cpuBusIf.sv
// Synchronized bus status
// Carries the decoded inputs from the input synchronizer to the cycle FSM

`timescale 1ns/100ps

interface cpuBusIf import cpuBusPkg::*; ();

    logic      grant;      // Bus granted to us
    logic      dmaEna;
    logic      dreq;       // SCSI side wants a transfer
    logic      flush;
    logic      busIdle;    // AS_ and BGACK_I_ both released
    portSize_e portSize;
    logic      cycleDone;  // Any DSACK termination present

    modport sync (
        output grant,
        output dmaEna,
        output dreq,
        output flush,
        output busIdle,
        output portSize,
        output cycleDone
    );

    modport sm (
        input grant,
        input dmaEna,
        input dreq,
        input flush,
        input busIdle,
        input portSize,
        input cycleDone
    );

endinterface

//--- design/cpuInputSync.sv
// Input synchronizer and termination decoder
// Brings the asynchronous bus inputs into the BCLK domain and decodes
// the DSACK pair into a port size and a cycle-done level

`timescale 1ns/100ps

`include "cpu_defines.svh"

module cpuInputSync import cpuBusPkg::*; (
    input  logic    BCLK,
    input  logic    CCRESET_,
    input  logic    aBGRANT_,
    input  logic    aDMAENA,
    input  logic    aDREQ_,
    input  logic    aFLUSHFIFO,
    input  logic    AS_,
    input  logic    BGACK_I_,
    input  logic    DSACK0_,
    input  logic    DSACK1_,
    cpuBusIf.sync   sync
);

    localparam int numIn = 8;

    // Inactive level of each input, same bit order as rawIn
    localparam logic [numIn-1:0] inactiveLvl = 8'b1111_0101;

    logic [numIn-1:0]                    rawIn;
    logic [`SYNC_STAGES-1:0][numIn-1:0]  syncChain;
    logic [numIn-1:0]                    syncOut;

    logic       bgrantSync_;
    logic       dmaEnaSync;
    logic       dreqSync_;
    logic       flushSync;
    logic       asSync_;
    logic       bgackInSync_;
    logic [1:0] dsackSync_;

    assign rawIn = {DSACK1_, DSACK0_, BGACK_I_, AS_, aFLUSHFIFO, aDREQ_, aDMAENA, aBGRANT_};

    // Shift chain, every stage resets to the inactive bus levels
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            syncChain <= {`SYNC_STAGES{inactiveLvl}};
        end else begin
            syncChain[0] <= rawIn;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                syncChain[i] <= syncChain[i-1];
            end
        end
    end

    assign syncOut = syncChain[`SYNC_STAGES-1];

    assign bgrantSync_  = syncOut[0];
    assign dmaEnaSync   = syncOut[1];
    assign dreqSync_    = syncOut[2];
    assign flushSync    = syncOut[3];
    assign asSync_      = syncOut[4];
    assign bgackInSync_ = syncOut[5];
    assign dsackSync_   = syncOut[7:6];

    assign sync.grant   = ~bgrantSync_;
    assign sync.dmaEna  = dmaEnaSync;
    assign sync.dreq    = ~dreqSync_;
    assign sync.flush   = flushSync;
    assign sync.busIdle = asSync_ & bgackInSync_;

    // Dynamic bus sizing, pair is {DSACK1_, DSACK0_}
    always_comb begin
        case (dsackSync_)
            2'b00:   sync.portSize = PORT_32;
            2'b01:   sync.portSize = PORT_16;
            // Byte ports are not served, treated as a single cycle
            default: sync.portSize = PORT_NONE;
        endcase
    end

    assign sync.cycleDone = ~&dsackSync_;

endmodule

//--- design/cpuCycleSm.sv
// Bus cycle state machine
// Arbitrates for the bus, runs one longword per tenure with an optional
// 16-bit split, then steps the FIFO and address

`timescale 1ns/100ps

module cpuCycleSm import cpuBusPkg::*; (
    input  logic      BCLK,
    input  logic      CCRESET_,
    input  logic      DMADIR,
    input  logic      FIFOEMPTY,
    input  logic      FIFOFULL,
    cpuBusIf.sm       sm,
    output cpuState_e nextState,
    output dmaDir_e   dmaDir
);

    cpuState_e state;
    dmaDir_e   dirSync;      // Direction seen in the current cycle
    portSize_e sizeReg;      // Size recorded at the first termination
    logic      secondHalf;
    logic      canMove;
    logic      splitWord;

    // Registered direction, latched into dmaDir when a tenure starts
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dirSync <= DIR_TO_FIFO;
            dmaDir  <= DIR_TO_FIFO;
        end else begin
            dirSync <= dmaDir_e'(DMADIR);
            if (state == ST_IDLE && nextState == ST_REQ) begin
                dmaDir <= dirSync;
            end
        end
    end

    // FIFO has room for a read, or holds a longword for a write
    always_comb begin
        if (dirSync == DIR_TO_FIFO) begin
            canMove = ~FIFOFULL;
        end else begin
            canMove = ~FIFOEMPTY;
        end
    end

    assign splitWord = (sizeReg == PORT_16) && !secondHalf;

    always_comb begin
        nextState = state;
        case (state)
            ST_IDLE: begin
                // Flush of an empty FIFO wins over a new request
                if (sm.flush && FIFOEMPTY) begin
                    nextState = ST_FLUSHSTOP;
                end else if (sm.dmaEna && sm.dreq && canMove) begin
                    nextState = ST_REQ;
                end
            end
            ST_REQ: begin
                if (sm.grant && sm.busIdle) begin
                    nextState = ST_TAKE;
                end
            end
            ST_TAKE: begin
                nextState = ST_ADDR;
            end
            ST_ADDR: begin
                nextState = ST_DATA;
            end
            ST_DATA: begin
                if (sm.cycleDone) begin
                    nextState = ST_GAP;
                end
            end
            ST_GAP: begin
                // Hold until the slave lets go of DSACK
                if (!sm.cycleDone) begin
                    if (splitWord) begin
                        nextState = ST_ADDR2;
                    end else begin
                        nextState = ST_STEP;
                    end
                end
            end
            ST_ADDR2: begin
                nextState = ST_DATA2;
            end
            ST_DATA2: begin
                if (sm.cycleDone) begin
                    nextState = ST_GAP;
                end
            end
            ST_STEP: begin
                nextState = ST_IDLE;
            end
            ST_FLUSHSTOP: begin
                if (!sm.flush) begin
                    nextState = ST_IDLE;
                end
            end
            default: begin
                nextState = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Port size of the first half decides whether a second half follows
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            sizeReg <= PORT_NONE;
        end else if (state == ST_DATA && sm.cycleDone) begin
            sizeReg <= sm.portSize;
        end
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            secondHalf <= 1'b0;
        end else if (nextState == ST_ADDR2) begin
            secondHalf <= 1'b1;
        end else if (nextState == ST_IDLE) begin
            secondHalf <= 1'b0;
        end
    end

endmodule

//--- design/cpuStrobeGen.sv
// Registered strobe generator
// Decodes the next state and direction into the bus, half-word and
// FIFO step strobes, registered on BCLK

`timescale 1ns/100ps

module cpuStrobeGen import cpuBusPkg::*; (
    input  logic      BCLK,
    input  logic      CCRESET_,
    input  cpuState_e nextState,
    input  dmaDir_e   dmaDir,
    output logic      BREQ,
    output logic      BGACK,
    output logic      PAS,
    output logic      PDS,
    output logic      SIZE1,
    output logic      PLHW,
    output logic      PLLW,
    output logic      F2CPUH,
    output logic      F2CPUL,
    output logic      INCFIFO,
    output logic      DECFIFO,
    output logic      INCNO,
    output logic      STOPFLUSH
);

    logic toFifo;
    logic firstData;
    logic secondData;
    logic stepNow;
    logic ownBus;
    logic firstHalf;
    logic secondHalf;

    assign toFifo     = (dmaDir == DIR_TO_FIFO);
    assign firstData  = (nextState == ST_DATA);
    assign secondData = (nextState == ST_DATA2);
    assign stepNow    = (nextState == ST_STEP);
    assign firstHalf  = (nextState == ST_ADDR) || firstData;
    assign secondHalf = (nextState == ST_ADDR2) || secondData;

    // BGACK spans the whole tenure from TAKE through STEP
    always_comb begin
        case (nextState)
            ST_TAKE, ST_ADDR, ST_DATA, ST_GAP,
            ST_ADDR2, ST_DATA2, ST_STEP: ownBus = 1'b1;
            default:                     ownBus = 1'b0;
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            BREQ      <= 1'b0;
            BGACK     <= 1'b0;
            PAS       <= 1'b0;
            PDS       <= 1'b0;
            SIZE1     <= 1'b0;
            PLHW      <= 1'b0;
            PLLW      <= 1'b0;
            F2CPUH    <= 1'b0;
            F2CPUL    <= 1'b0;
            INCFIFO   <= 1'b0;
            DECFIFO   <= 1'b0;
            INCNO     <= 1'b0;
            STOPFLUSH <= 1'b0;
        end else begin
            BREQ      <= (nextState == ST_REQ);
            BGACK     <= ownBus;
            PAS       <= firstHalf || secondHalf;
            PDS       <= firstData || secondData;
            SIZE1     <= secondHalf;
            // The first data phase carries both halves, since the port size
            // is unknown until termination; a 16-bit port only uses the
            // upper lanes and the low half is repeated in the second phase
            PLHW      <= toFifo && firstData;
            PLLW      <= toFifo && (firstData || secondData);
            F2CPUH    <= !toFifo && firstData;
            F2CPUL    <= !toFifo && (firstData || secondData);
            INCFIFO   <= toFifo && stepNow;
            DECFIFO   <= !toFifo && stepNow;
            INCNO     <= stepNow;
            STOPFLUSH <= (nextState == ST_FLUSHSTOP);
        end
    end

endmodule

//--- design/cpuBusMaster.sv
// SCSI DMA CPU-side bus master
// Moves longwords between the FIFO and a 68030-style asynchronous bus

`timescale 1ns/100ps

module cpuBusMaster import cpuBusPkg::*; (
    input  logic BCLK,
    input  logic CCRESET_,
    input  logic aBGRANT_,
    input  logic aDMAENA,
    input  logic aDREQ_,
    input  logic aFLUSHFIFO,
    input  logic AS_,
    input  logic BGACK_I_,
    input  logic DSACK0_,
    input  logic DSACK1_,
    input  logic DMADIR,
    input  logic FIFOEMPTY,
    input  logic FIFOFULL,
    output logic BREQ,
    output logic BGACK,
    output logic PAS,
    output logic PDS,
    output logic SIZE1,
    output logic PLHW,
    output logic PLLW,
    output logic F2CPUH,
    output logic F2CPUL,
    output logic INCFIFO,
    output logic DECFIFO,
    output logic INCNO,
    output logic STOPFLUSH
);

    cpuState_e nextState;
    dmaDir_e   dmaDir;

    cpuBusIf busIf ();

    cpuInputSync u_inputSync (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .aBGRANT_   (aBGRANT_),
        .aDMAENA    (aDMAENA),
        .aDREQ_     (aDREQ_),
        .aFLUSHFIFO (aFLUSHFIFO),
        .AS_        (AS_),
        .BGACK_I_   (BGACK_I_),
        .DSACK0_    (DSACK0_),
        .DSACK1_    (DSACK1_),
        .sync       (busIf.sync)
    );

    cpuCycleSm u_cycleSm (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .DMADIR    (DMADIR),
        .FIFOEMPTY (FIFOEMPTY),
        .FIFOFULL  (FIFOFULL),
        .sm        (busIf.sm),
        .nextState (nextState),
        .dmaDir    (dmaDir)
    );

    cpuStrobeGen u_strobeGen (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .nextState (nextState),
        .dmaDir    (dmaDir),
        .BREQ      (BREQ),
        .BGACK     (BGACK),
        .PAS       (PAS),
        .PDS       (PDS),
        .SIZE1     (SIZE1),
        .PLHW      (PLHW),
        .PLLW      (PLLW),
        .F2CPUH    (F2CPUH),
        .F2CPUL    (F2CPUL),
        .INCFIFO   (INCFIFO),
        .DECFIFO   (DECFIFO),
        .INCNO     (INCNO),
        .STOPFLUSH (STOPFLUSH)
    );

endmodule

//--- tests/cpuBusMasterTb.sv
// Testbench for the CPU-side bus master
// Directed tests against a DSACK slave model with random wait states

`timescale 1ns/100ps

module cpuBusMasterTb import cpuBusPkg::*; ();

    // Six tests, at most 8 longwords each, about 80 cycles per longword, plus reset
    localparam int timeoutCycles = 6 * 8 * 80 + 160;

    logic BCLK;
    logic CCRESET_;
    logic aBGRANT_, aDMAENA, aDREQ_, aFLUSHFIFO, AS_, BGACK_I_;
    logic DSACK0_, DSACK1_, DMADIR, FIFOEMPTY, FIFOFULL;
    logic BREQ, BGACK, PAS, PDS, SIZE1, PLHW, PLLW, F2CPUH, F2CPUL;
    logic INCFIFO, DECFIFO, INCNO, STOPFLUSH;
    logic [12:0] allOuts;

    portSize_e slavePort;
    int        slaveMinWait;
    int        slaveWait;
    int        stepTotal;
    int        cycleCount;

    cpuBusMaster uut (.*);

    assign allOuts = {BREQ, BGACK, PAS, PDS, SIZE1, PLHW, PLLW, F2CPUH, F2CPUL,
                      INCFIFO, DECFIFO, INCNO, STOPFLUSH};

    initial begin
        BCLK = 1'b0;
        forever #5 BCLK = ~BCLK;
    end

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch at %0t: %s is %b, expected %b",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkPort(input portSize_e actual, input portSize_e expected,
                             input string what);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
                              $time, what, actual.name(), expected.name()));
        end
    endtask

    task automatic checkDir(input dmaDir_e actual, input dmaDir_e expected, input string what);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
                              $time, what, actual.name(), expected.name()));
        end
    endtask

    // Slave answers each PDS after a random wait and lets go of DSACK when PDS falls
    always begin
        @(negedge BCLK);
        if (PDS) begin
            slaveWait = slaveMinWait + ($urandom % 8);
            repeat (slaveWait) begin
                @(negedge BCLK);
                checkBit(PDS, 1'b1, "PDS during slave wait");
            end
            DSACK1_ = 1'b0;
            DSACK0_ = (slavePort == PORT_16);
            while (PDS) @(negedge BCLK);
            DSACK1_ = 1'b1;
            DSACK0_ = 1'b1;
        end
    end

    always @(negedge BCLK) begin
        if (INCNO) begin
            stepTotal = stepTotal + 1;
        end
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge BCLK);
            cycleCount++;
        end
        failRun($sformatf("Timeout: the tests did not finish within %0d cycles", timeoutCycles));
    end

    task automatic expectNoRequest(input int cycles);
        repeat (cycles) begin
            @(negedge BCLK);
            checkBit(BREQ, 1'b0, "BREQ while the request is gated");
        end
    endtask

    task automatic expectNoTake(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge BCLK);
            checkBit(BGACK, 1'b0, what);
            checkBit(BREQ, 1'b1, "BREQ while waiting for the bus");
        end
    endtask

    // One tenure on a free bus, checking strobe order, half markers and step pulses
    task automatic runLongword(input dmaDir_e dir, input portSize_e port);
        int      pdsRises;
        int      incCycles;
        int      decCycles;
        int      incnoCycles;
        logic    pdsPrev;
        logic    pasPrev;
        logic    hiMark;
        logic    loMark;
        dmaDir_e seenDir;
        pdsRises = 0;
        incCycles = 0;
        decCycles = 0;
        incnoCycles = 0;
        pdsPrev = 1'b0;
        pasPrev = 1'b0;
        DMADIR = dir;
        slavePort = port;
        aBGRANT_ = 1'b0;
        aDMAENA = 1'b1;
        @(negedge BCLK);
        aDREQ_ = 1'b0;
        while (!(incnoCycles > 0 && !BGACK)) begin
            @(negedge BCLK);
            hiMark = (dir == DIR_TO_FIFO) ? PLHW : F2CPUH;
            loMark = (dir == DIR_TO_FIFO) ? PLLW : F2CPUL;
            checkBit((dir == DIR_TO_FIFO) ? (F2CPUH | F2CPUL) : (PLHW | PLLW), 1'b0,
                     "half markers of the other direction");
            if (PDS) begin
                checkBit(PAS, 1'b1, "PAS while PDS is high");
            end
            // Address and data strobes end the cycle together
            if (!PDS && pdsPrev) begin
                checkBit(PAS, 1'b0, "PAS once PDS has fallen");
            end
            if (PDS && !pdsPrev) begin
                // One request per tenure
                aDREQ_ = 1'b1;
                checkBit(pasPrev, 1'b1, "PAS in the cycle before PDS");
                checkBit(hiMark, pdsRises == 0, "high half marker");
                checkBit(loMark, 1'b1, "low half marker");
                checkBit(SIZE1, pdsRises != 0, "SIZE1");
                pdsRises++;
            end
            incCycles += INCFIFO;
            decCycles += DECFIFO;
            incnoCycles += INCNO;
            pdsPrev = PDS;
            pasPrev = PAS;
        end
        checkBit(incnoCycles == 1, 1'b1, "single one-cycle INCNO pulse");
        checkBit(incCycles + decCycles == 1, 1'b1, "single one-cycle FIFO step pulse");
        seenDir = (decCycles > 0) ? DIR_FROM_FIFO : DIR_TO_FIFO;
        checkDir(seenDir, dir, "FIFO step direction");
        checkPort((pdsRises == 2) ? PORT_16 : PORT_32, port, "port size from data cycles");
    endtask

    task automatic resetOutputs();
        repeat (8) begin
            @(negedge BCLK);
            checkBit(|allOuts, 1'b0, "any output during reset");
        end
        CCRESET_ = 1'b1;
        // Request pending but DMA disabled
        aDREQ_ = 1'b0;
        repeat (12) begin
            @(negedge BCLK);
            checkBit(|allOuts, 1'b0, "any output with DMAENA low");
        end
        aDREQ_ = 1'b1;
    endtask

    task automatic arbitrationOrder();
        aBGRANT_ = 1'b1;
        AS_ = 1'b1;
        BGACK_I_ = 1'b1;
        DMADIR = DIR_TO_FIFO;
        slavePort = PORT_32;
        aDMAENA = 1'b1;
        aDREQ_ = 1'b0;
        while (!BREQ) @(negedge BCLK);
        expectNoTake(10, "BGACK without grant");
        // Grant arrives while another master still drives AS_
        AS_ = 1'b0;
        aBGRANT_ = 1'b0;
        expectNoTake(10, "BGACK while AS_ is low");
        AS_ = 1'b1;
        BGACK_I_ = 1'b0;
        expectNoTake(10, "BGACK while BGACK_I_ is low");
        BGACK_I_ = 1'b1;
        while (!BGACK) @(negedge BCLK);
        checkBit(BREQ, 1'b0, "BREQ once BGACK is high");
        aDREQ_ = 1'b1;
        while (!INCFIFO) @(negedge BCLK);
        while (BGACK) @(negedge BCLK);
    endtask

    task automatic word32ToFifo();
        slaveMinWait = 0;
        runLongword(DIR_TO_FIFO, PORT_32);
    endtask

    task automatic word16FromFifo();
        slaveMinWait = 0;
        runLongword(DIR_FROM_FIFO, PORT_16);
    endtask

    task automatic backPressureAndGating();
        int stepBase;
        slaveMinWait = 30;
        runLongword(DIR_TO_FIFO, PORT_32);
        slaveMinWait = 0;
        // Empty FIFO cannot feed a memory write
        DMADIR = DIR_FROM_FIFO;
        FIFOEMPTY = 1'b1;
        repeat (3) @(negedge BCLK);
        aDREQ_ = 1'b0;
        expectNoRequest(20);
        aDREQ_ = 1'b1;
        repeat (4) @(negedge BCLK);
        // Full FIFO cannot take a memory read
        DMADIR = DIR_TO_FIFO;
        FIFOEMPTY = 1'b0;
        FIFOFULL = 1'b1;
        repeat (3) @(negedge BCLK);
        aDREQ_ = 1'b0;
        expectNoRequest(20);
        aDREQ_ = 1'b1;
        repeat (4) @(negedge BCLK);
        FIFOFULL = 1'b0;
        stepBase = stepTotal;
        repeat (5) begin
            runLongword(dmaDir_e'($urandom % 2), ($urandom % 2) ? PORT_16 : PORT_32);
        end
        checkBit(stepTotal - stepBase == 5, 1'b1, "step pulses over five longwords");
    endtask

    task automatic flushEmptyFifo();
        DMADIR = DIR_TO_FIFO;
        FIFOEMPTY = 1'b1;
        aFLUSHFIFO = 1'b1;
        // A memory read could start here, the flush has to win
        aDREQ_ = 1'b0;
        while (!STOPFLUSH) begin
            @(negedge BCLK);
            checkBit(BREQ, 1'b0, "BREQ while the flush is pending");
        end
        repeat (6) begin
            @(negedge BCLK);
            checkBit(STOPFLUSH, 1'b1, "STOPFLUSH while flushing");
            checkBit(BREQ, 1'b0, "BREQ during flush");
        end
        aFLUSHFIFO = 1'b0;
        aDREQ_ = 1'b1;
        while (STOPFLUSH) @(negedge BCLK);
        expectNoRequest(4);
        FIFOEMPTY = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h477d_c134));
        CCRESET_ = 1'b0;
        aBGRANT_ = 1'b1;
        aDMAENA = 1'b0;
        aDREQ_ = 1'b1;
        aFLUSHFIFO = 1'b0;
        AS_ = 1'b1;
        BGACK_I_ = 1'b1;
        DSACK0_ = 1'b1;
        DSACK1_ = 1'b1;
        DMADIR = DIR_TO_FIFO;
        FIFOEMPTY = 1'b0;
        FIFOFULL = 1'b0;
        slavePort = PORT_32;
        slaveMinWait = 0;
        stepTotal = 0;
        resetOutputs();
        arbitrationOrder();
        word32ToFifo();
        word16FromFifo();
        backPressureAndGating();
        flushEmptyFifo();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- cpuBusMaster.f
+incdir+design
design/cpuBusPkg.sv
design/cpuBusIf.sv
design/cpuInputSync.sv
design/cpuCycleSm.sv
design/cpuStrobeGen.sv
design/cpuBusMaster.sv
tests/cpuBusMasterTb.sv

//--- Bender.yml
package:
  name: cpu_bus_master

sources:
  - include_dirs:
      - design
    files:
      - design/cpuBusPkg.sv
      - design/cpuBusIf.sv
      - design/cpuInputSync.sv
      - design/cpuCycleSm.sv
      - design/cpuStrobeGen.sv
      - design/cpuBusMaster.sv
  - target: test
    files:
      - tests/cpuBusMasterTb.sv
